// ==== Bender.yml ====
package:
  name: gpu_host

export_include_dirs:
  - logic

sources:
  - files:
      - logic/gpu_host_pkg.sv
      - logic/host_reg_bridge.sv
      - logic/test_pattern_video.sv
      - logic/gpu_host_top.sv
  - target: test
    files:
      - verif/gpu_host_sva.sv
      - verif/gpu_host_tb.sv

// ==== build.f ====
+incdir+logic
logic/gpu_host_pkg.sv
logic/host_reg_bridge.sv
logic/test_pattern_video.sv
logic/gpu_host_top.sv
verif/gpu_host_sva.sv
verif/gpu_host_tb.sv

// ==== logic/gpu_host_consts.svh ====
// GPU host glue constants
// bus widths, bridge register offsets, DDR framebuffer window and raster timing
`ifndef GPU_HOST_CONSTS_SVH
`define GPU_HOST_CONSTS_SVH

// ==================================================
// host register bridge
// ==================================================
`define GH_HOST_ADDR_W  20      // word-addressed host bus
`define GH_REG_SEL_W    4       // low bits that pick the register
`define GH_OFS_GP0      4'h0
`define GH_OFS_GP1      4'h4
`define GH_OFS_FLAGS    4'h8    // flags / control
`define GH_OFS_DMA      4'hC    // dma data port

// framebuffer window into DDR (64-bit word addresses)
`define GH_MEM_ADDR_W   17
`define GH_DDR_ADDR_W   29
`define GH_DDR_BASE     12'h100 // byte address 0x1000_0000

// raster, line counter is 9 bits and wraps at 512 on its own
`define GH_H_TOTAL      10'd768
`define GH_H_ACTIVE     10'd640
`define GH_V_ACTIVE     9'd480
`define GH_HS_CODE      6'd45   // pixels 720..735
`define GH_VS_FIRST     9'd500
`define GH_VS_LAST      9'd506
`endif

// ==== logic/gpu_host_pkg.sv ====
// GPU host glue types
// bridge FSM states, register-select opcodes, bus word and aspect selection
package gpu_host_pkg;

	typedef logic [31:0] word_t;   // one host / GPU bus word

	// bridge FSM
	typedef enum logic [1:0] {
		bs_idle,          // waiting for a host request
		bs_write_done,    // strobe out, release the host next edge
		bs_read_wait      // waiting on GPU data valid
	} bridge_state_e;

	// decoded register offset
	typedef enum logic [2:0] {
		rs_gp0,
		rs_gp1,
		rs_flags,
		rs_dma,
		rs_unmapped
	} reg_sel_e;

	typedef enum logic [1:0] {asp_4_3, asp_8_7, asp_16_9, asp_2_1} aspect_e;

endpackage

// ==== logic/gpu_host_top.sv ====
// GPU host glue top level
// host register bridge, test-pattern video and the framebuffer DDR window
`timescale 1ns/10ps
`include "gpu_host_consts.svh"

module gpu_host_top (
	input  logic                       clk_sys,
	input  logic                       reset,
	// host bus
	input  logic [`GH_HOST_ADDR_W-1:0] i_host_address,
	input  logic                       i_host_write,
	input  logic                       i_host_read,
	input  gpu_host_pkg::word_t        i_host_writedata,
	output logic                       o_host_waitrequest,
	output gpu_host_pkg::word_t        o_host_readdata,
	output logic                       o_host_readdatavalid,
	// GPU register side
	input  gpu_host_pkg::word_t        i_gpu_data_out,
	input  logic                       i_gpu_data_valid,
	input  logic                       i_gpu_irq,
	input  logic                       i_gpu_dma_req,
	input  logic                       i_gpu_can_write,
	input  gpu_host_pkg::word_t        i_gpu_debug_cnt,
	output logic                       o_gpu_sel,
	output logic                       o_gpu_a2,
	output logic                       o_gpu_write,
	output logic                       o_gpu_read,
	output gpu_host_pkg::word_t        o_gpu_data_in,
	output logic                       o_gpu_dma_ack,
	output logic                       o_gpu_nrst,
	// video
	input  gpu_host_pkg::aspect_e      i_aspect,
	output logic [7:0]                 o_red,
	output logic [7:0]                 o_green,
	output logic [7:0]                 o_blue,
	output logic                       o_hsync,
	output logic                       o_vsync,
	output logic                       o_de,
	output logic [7:0]                 o_aspect_x,
	output logic [7:0]                 o_aspect_y,
	// framebuffer controller to DDR, write path only
	input  logic [`GH_MEM_ADDR_W-1:0]  i_mem_addr,
	input  logic [2:0]                 i_mem_burst,
	input  logic                       i_mem_we,
	input  logic                       i_mem_rd,
	input  logic [63:0]                i_mem_data,
	input  logic [7:0]                 i_mem_be,
	output logic [`GH_DDR_ADDR_W-1:0]  o_ddr_addr,
	output logic [7:0]                 o_ddr_burstcnt,
	output logic                       o_ddr_we,
	output logic                       o_ddr_rd,
	output logic [63:0]                o_ddr_din,
	output logic [7:0]                 o_ddr_be
);

	host_reg_bridge host_reg_bridge_i (
		.clk_sys, .reset,
		.i_host_address, .i_host_write, .i_host_read, .i_host_writedata,
		.i_gpu_data_out, .i_gpu_data_valid, .i_gpu_irq, .i_gpu_dma_req,
		.i_gpu_can_write, .i_gpu_debug_cnt,
		.o_host_waitrequest, .o_host_readdata, .o_host_readdatavalid,
		.o_gpu_sel, .o_gpu_a2, .o_gpu_write, .o_gpu_read, .o_gpu_data_in,
		.o_gpu_dma_ack, .o_gpu_nrst
	);

	test_pattern_video test_pattern_video_i (
		.clk_sys, .reset, .i_aspect,
		.o_red, .o_green, .o_blue, .o_hsync, .o_vsync, .o_de,
		.o_aspect_x, .o_aspect_y
	);

	// ==================================================
	// DDR window, same-cycle wiring
	// ==================================================
	assign o_ddr_addr     = {`GH_DDR_BASE, i_mem_addr};   // base above the 17-bit word address
	assign o_ddr_burstcnt = {5'd0, i_mem_burst};          // zero-extend
	assign o_ddr_we       = i_mem_we;
	assign o_ddr_rd       = i_mem_rd;
	assign o_ddr_din      = i_mem_data;
	assign o_ddr_be       = i_mem_be;   // active high, byte order unchanged

endmodule

// ==== logic/host_reg_bridge.sv ====
// Host register bridge
// turns the wait-request host bus into GP0/GP1 strobes, a flags/control
// register and the DMA data port of the GPU
`timescale 1ns/10ps
`include "gpu_host_consts.svh"

module host_reg_bridge (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic [`GH_HOST_ADDR_W-1:0] i_host_address,
	input  logic                       i_host_write,
	input  logic                       i_host_read,
	input  gpu_host_pkg::word_t        i_host_writedata,
	input  gpu_host_pkg::word_t        i_gpu_data_out,
	input  logic                       i_gpu_data_valid,
	input  logic                       i_gpu_irq,
	input  logic                       i_gpu_dma_req,
	input  logic                       i_gpu_can_write,
	input  gpu_host_pkg::word_t        i_gpu_debug_cnt,
	output logic                       o_host_waitrequest,
	output gpu_host_pkg::word_t        o_host_readdata,
	output logic                       o_host_readdatavalid,
	output logic                       o_gpu_sel,
	output logic                       o_gpu_a2,
	output logic                       o_gpu_write,
	output logic                       o_gpu_read,
	output gpu_host_pkg::word_t        o_gpu_data_in,
	output logic                       o_gpu_dma_ack,
	output logic                       o_gpu_nrst
);

	gpu_host_pkg::bridge_state_e state;
	gpu_host_pkg::reg_sel_e      reg_sel;
	gpu_host_pkg::word_t         flags_word;
	logic                        run_bit;    // flags bit 30, GPU out of reset
	logic                        rst_done;   // low until first edge after reset
	logic                        accept_wr;
	logic                        accept_rd;

	// ==================================================
	// offset decode
	// ==================================================
	always_comb begin
		if (i_host_address[`GH_HOST_ADDR_W-1:`GH_REG_SEL_W] != '0) begin
			reg_sel = gpu_host_pkg::rs_unmapped;   // no aliasing above the window
		end else begin
			case (i_host_address[`GH_REG_SEL_W-1:0])
				`GH_OFS_GP0:   reg_sel = gpu_host_pkg::rs_gp0;
				`GH_OFS_GP1:   reg_sel = gpu_host_pkg::rs_gp1;
				`GH_OFS_FLAGS: reg_sel = gpu_host_pkg::rs_flags;
				`GH_OFS_DMA:   reg_sel = gpu_host_pkg::rs_dma;
				default:       reg_sel = gpu_host_pkg::rs_unmapped;
			endcase
		end
	end

	// request taken only from idle with waitrequest low, write wins
	assign accept_wr = (state == gpu_host_pkg::bs_idle) && !o_host_waitrequest && i_host_write;
	assign accept_rd = (state == gpu_host_pkg::bs_idle) && !o_host_waitrequest &&
		!i_host_write && i_host_read;

	// status word: 0, dma_req, irq, can_write, debug count low bits
	assign flags_word = {1'b0, i_gpu_dma_req, i_gpu_irq, i_gpu_can_write,
		i_gpu_debug_cnt[27:0]};

	assign o_gpu_nrst = run_bit & rst_done;

	// ==================================================
	// bridge FSM
	// ==================================================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state                <= gpu_host_pkg::bs_idle;
			o_host_waitrequest   <= 1'b1;   // hold host off during reset
			o_host_readdatavalid <= 1'b0;
			o_gpu_sel            <= 1'b0;
			o_gpu_a2             <= 1'b0;
			o_gpu_write          <= 1'b0;
			o_gpu_read           <= 1'b0;
			o_gpu_dma_ack        <= 1'b0;
			run_bit              <= 1'b1;   // GPU runs by default
			rst_done             <= 1'b0;
		end else begin
			rst_done             <= 1'b1;
			o_gpu_sel            <= 1'b0;   // strobes are single pulses
			o_gpu_write          <= 1'b0;
			o_gpu_read           <= 1'b0;
			o_gpu_dma_ack        <= 1'b0;
			o_host_readdatavalid <= 1'b0;
			case (state)
				gpu_host_pkg::bs_idle: begin
					o_host_waitrequest <= 1'b0;
					if (accept_wr) begin
						case (reg_sel)
							gpu_host_pkg::rs_gp0, gpu_host_pkg::rs_gp1: begin
								o_gpu_a2           <= (reg_sel == gpu_host_pkg::rs_gp1);
								o_gpu_sel          <= 1'b1;
								o_gpu_write        <= 1'b1;
								o_host_waitrequest <= 1'b1;
								state              <= gpu_host_pkg::bs_write_done;
							end
							gpu_host_pkg::rs_dma: begin
								o_gpu_a2           <= 1'b0;
								o_gpu_write        <= 1'b1;   // no sel on the dma port
								o_gpu_dma_ack      <= 1'b1;
								o_host_waitrequest <= 1'b1;
								state              <= gpu_host_pkg::bs_write_done;
							end
							gpu_host_pkg::rs_flags: begin
								o_gpu_dma_ack      <= i_host_writedata[31];
								run_bit            <= i_host_writedata[30];
								o_host_waitrequest <= 1'b1;
								state              <= gpu_host_pkg::bs_write_done;
							end
							default: ;   // unmapped write dropped
						endcase
					end else if (accept_rd) begin
						case (reg_sel)
							gpu_host_pkg::rs_gp0, gpu_host_pkg::rs_gp1: begin
								o_gpu_a2           <= (reg_sel == gpu_host_pkg::rs_gp1);
								o_gpu_sel          <= 1'b1;
								o_gpu_read         <= 1'b1;
								o_host_waitrequest <= 1'b1;
								state              <= gpu_host_pkg::bs_read_wait;
							end
							default: o_host_readdatavalid <= 1'b1;   // local, answer at once
						endcase
					end
				end
				gpu_host_pkg::bs_write_done: begin
					o_host_waitrequest <= 1'b0;   // host may still hold request, drop it now
					state              <= gpu_host_pkg::bs_idle;
				end
				gpu_host_pkg::bs_read_wait: begin
					if (i_gpu_data_valid) begin   // latency set by the GPU
						o_host_readdatavalid <= 1'b1;
						o_host_waitrequest   <= 1'b0;
						state                <= gpu_host_pkg::bs_idle;
					end
				end
				default: state <= gpu_host_pkg::bs_idle;
			endcase
		end
	end

	// data words
	always_ff @(posedge clk_sys) begin
		if (accept_wr && (reg_sel inside {gpu_host_pkg::rs_gp0, gpu_host_pkg::rs_gp1,
			gpu_host_pkg::rs_dma})) begin
			o_gpu_data_in <= i_host_writedata;
		end
		if (accept_rd) begin
			case (reg_sel)
				gpu_host_pkg::rs_flags:    o_host_readdata <= flags_word;
				gpu_host_pkg::rs_dma:      o_host_readdata <= i_gpu_data_out;
				gpu_host_pkg::rs_unmapped: o_host_readdata <= '0;
				default: ;   // GP0/GP1 filled when valid arrives
			endcase
		end else if (state == gpu_host_pkg::bs_read_wait && i_gpu_data_valid) begin
			o_host_readdata <= i_gpu_data_out;
		end
	end

endmodule

// ==== logic/test_pattern_video.sv ====
// Test-pattern video generator
// free-running 768-wide raster with sync and enable windows, XOR colours
// and the aspect ratio for the selected mode
`timescale 1ns/10ps
`include "gpu_host_consts.svh"

module test_pattern_video (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  gpu_host_pkg::aspect_e i_aspect,
	output logic [7:0]            o_red,
	output logic [7:0]            o_green,
	output logic [7:0]            o_blue,
	output logic                  o_hsync,
	output logic                  o_vsync,
	output logic                  o_de,
	output logic [7:0]            o_aspect_x,
	output logic [7:0]            o_aspect_y
);

	logic [9:0] hcnt;   // pixel in line
	logic [8:0] vcnt;   // line, 0..511

	// ==================================================
	// raster counters
	// ==================================================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (hcnt == `GH_H_TOTAL - 10'd1) begin
			hcnt <= '0;
			vcnt <= vcnt + 9'd1;   // wraps at 512 by width
		end else begin
			hcnt <= hcnt + 10'd1;
		end
	end

	assign o_hsync = (hcnt[9:4] == `GH_HS_CODE);   // 16 pixel pulse
	assign o_vsync = (vcnt >= `GH_VS_FIRST) && (vcnt <= `GH_VS_LAST);
	assign o_de    = (hcnt < `GH_H_ACTIVE) && (vcnt < `GH_V_ACTIVE);

	// xor pattern
	assign o_red   = hcnt[7:0] ^ vcnt[8:1];
	assign o_green = hcnt[8:1] ^ vcnt[7:0];
	assign o_blue  = hcnt[9:2] ^ vcnt[8:1];

	// ratio pair for the scaler
	always_comb begin
		case (i_aspect)
			gpu_host_pkg::asp_4_3: begin
				o_aspect_x = 8'd4;
				o_aspect_y = 8'd3;
			end
			gpu_host_pkg::asp_8_7: begin
				o_aspect_x = 8'd8;
				o_aspect_y = 8'd7;
			end
			gpu_host_pkg::asp_16_9: begin
				o_aspect_x = 8'd16;
				o_aspect_y = 8'd9;
			end
			default: begin   // 2:1
				o_aspect_x = 8'd2;
				o_aspect_y = 8'd1;
			end
		endcase
	end

endmodule

// ==== verif/gpu_host_sva.sv ====
// Bridge handshake assertions
// concurrent checks on the host handshake, GPU strobes and FSM return to idle
`timescale 1ns/10ps

module gpu_host_sva (
	input logic                        clk_sys,
	input logic                        reset,
	input gpu_host_pkg::bridge_state_e state,
	input logic                        i_gpu_data_valid,
	input logic                        o_host_readdatavalid,
	input logic                        o_gpu_sel,
	input logic                        o_gpu_write,
	input logic                        o_gpu_read,
	input logic                        o_gpu_dma_ack
);

	int unsigned fail_cnt = 0;   // read by the testbench at the end
	logic        strobe;         // any GPU-side pulse

	assign strobe = o_gpu_sel | o_gpu_write | o_gpu_read | o_gpu_dma_ack;

	// ==================================================
	// handshake properties
	// ==================================================
	a_strobe_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		strobe |=> !strobe)
	else begin
		$error("gpu strobe held for more than one cycle");
		fail_cnt++;
	end

	a_rdv_single: assert property (@(posedge clk_sys) disable iff (reset)
		o_host_readdatavalid |=> !o_host_readdatavalid)
	else begin
		$error("readdatavalid high for two cycles");
		fail_cnt++;
	end

	// busy states end one edge later, read_wait only once valid shows up
	a_idle_after_valid: assert property (@(posedge clk_sys) disable iff (reset)
		(state != gpu_host_pkg::bs_idle) &&
		(state != gpu_host_pkg::bs_read_wait || i_gpu_data_valid)
		|=> state == gpu_host_pkg::bs_idle)
	else begin
		$error("bridge did not return to idle");
		fail_cnt++;
	end

endmodule

bind host_reg_bridge gpu_host_sva gpu_host_sva_i (
	.clk_sys, .reset, .state, .i_gpu_data_valid, .o_host_readdatavalid,
	.o_gpu_sel, .o_gpu_write, .o_gpu_read, .o_gpu_dma_ack
);

// ==== verif/gpu_host_tb.sv ====
// GPU host glue testbench
// directed tests of the host bridge, DDR window and test-pattern video
`timescale 1ns/10ps
`include "gpu_host_consts.svh"

module gpu_host_tb;

	localparam int WAIT_LIMIT = 50;   // max cycles for any single wait

	logic                       clk_sys;
	logic                       reset;
	logic [`GH_HOST_ADDR_W-1:0] i_host_address;
	logic                       i_host_write;
	logic                       i_host_read;
	gpu_host_pkg::word_t        i_host_writedata;
	logic                       o_host_waitrequest;
	gpu_host_pkg::word_t        o_host_readdata;
	logic                       o_host_readdatavalid;
	gpu_host_pkg::word_t        i_gpu_data_out;
	gpu_host_pkg::word_t        i_gpu_debug_cnt;
	logic                       i_gpu_data_valid;
	logic                       i_gpu_irq;
	logic                       i_gpu_dma_req;
	logic                       i_gpu_can_write;
	logic                       o_gpu_sel;
	logic                       o_gpu_a2;
	logic                       o_gpu_write;
	logic                       o_gpu_read;
	gpu_host_pkg::word_t        o_gpu_data_in;
	logic                       o_gpu_dma_ack;
	logic                       o_gpu_nrst;
	gpu_host_pkg::aspect_e      i_aspect;
	logic [7:0]                 o_red;
	logic [7:0]                 o_green;
	logic [7:0]                 o_blue;
	logic                       o_hsync;
	logic                       o_vsync;
	logic                       o_de;
	logic [7:0]                 o_aspect_x;
	logic [7:0]                 o_aspect_y;
	logic [`GH_MEM_ADDR_W-1:0]  i_mem_addr;
	logic [2:0]                 i_mem_burst;
	logic                       i_mem_we;
	logic                       i_mem_rd;
	logic [63:0]                i_mem_data;
	logic [7:0]                 i_mem_be;
	logic [`GH_DDR_ADDR_W-1:0]  o_ddr_addr;
	logic [7:0]                 o_ddr_burstcnt;
	logic                       o_ddr_we;
	logic                       o_ddr_rd;
	logic [63:0]                o_ddr_din;
	logic [7:0]                 o_ddr_be;

	int                  errors;
	int                  tests_run;
	int                  tests_failed;
	int                  test_err0;      // error count when the test began
	string               test_name;
	int                  cyc;            // edges since reset release
	int                  valid_cyc;      // cyc when the responder raised valid
	gpu_host_pkg::word_t resp_word;      // last word the responder returned
	logic [31:0]         lfsr_state = 32'd35;

	gpu_host_top gpu_host_top_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;   // 40 ns
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) cyc <= 0;
		else       cyc <= cyc + 1;
	end

	// ==================================================
	// helpers
	// ==================================================
	// galois LFSR, x^32+x^22+x^2+x+1, one step per bit
	function automatic gpu_host_pkg::word_t next_bits(input int n);
		gpu_host_pkg::word_t r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_state[0]};
			if (lfsr_state[0]) lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			else               lfsr_state = lfsr_state >> 1;
		end
		return r;
	endfunction

	task automatic check_word(input string what, input gpu_host_pkg::word_t exp,
		input gpu_host_pkg::word_t act);
		if (exp !== act) begin
			$display("Error %s: %s expected %h actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Error %s: %s expected %b actual %b", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_aspect(input gpu_host_pkg::aspect_e sel, input logic [7:0] exp_x,
		input logic [7:0] exp_y);
		if ({exp_x, exp_y} !== {o_aspect_x, o_aspect_y}) begin
			$display("Error %s: aspect %s expected %0d:%0d actual %0d:%0d", test_name,
				sel.name(), exp_x, exp_y, o_aspect_x, o_aspect_y);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err0 = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors > test_err0) begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, errors - test_err0);
		end else begin
			$display("test %s: ok", test_name);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout in %s: %s", test_name, what);
		$display("Result: FAILED");
		$finish;
	endtask

	// called at a falling edge, returns at the falling edge in cycle A+1
	task automatic host_access(input logic is_write, input logic [`GH_HOST_ADDR_W-1:0] addr,
		input gpu_host_pkg::word_t data);
		int waited;
		waited           = 0;
		i_host_address   = addr;
		i_host_writedata = data;
		i_host_write     = is_write;
		i_host_read      = !is_write;
		while (o_host_waitrequest) begin   // hold until the bridge is free
			@(negedge clk_sys);
			waited++;
			if (waited > WAIT_LIMIT) stop_on_timeout("waitrequest never went low");
		end
		@(negedge clk_sys);
		i_host_write = 1'b0;
		i_host_read  = 1'b0;
	endtask

	task automatic wait_readvalid(output gpu_host_pkg::word_t d);
		int waited;
		waited = 0;
		while (!o_host_readdatavalid) begin
			@(negedge clk_sys);
			waited++;
			if (waited > WAIT_LIMIT) stop_on_timeout("readdatavalid never came");
		end
		d = o_host_readdata;
	endtask

	// GPU side of a register read, answers after 1..8 cycles
	initial begin : gpu_read_responder
		int lat;
		forever begin
			@(negedge clk_sys);
			if (o_gpu_read) begin
				lat       = 1 + int'(next_bits(3));
				resp_word = next_bits(32);
				repeat (lat) @(negedge clk_sys);
				i_gpu_data_out   = resp_word;
				i_gpu_data_valid = 1'b1;
				valid_cyc        = cyc;
				@(negedge clk_sys);
				i_gpu_data_valid = 1'b0;
			end
		end
	end

	// ==================================================
	// tests
	// ==================================================
	task automatic test_reset();
		start_test("reset");
		reset = 1'b1;
		repeat (5) @(negedge clk_sys);
		check_bit("waitrequest in reset", 1'b1, o_host_waitrequest);
		check_bit("readdatavalid in reset", 1'b0, o_host_readdatavalid);
		check_bit("strobes in reset", 1'b0, o_gpu_sel | o_gpu_write | o_gpu_read | o_gpu_dma_ack);
		check_bit("nrst in reset", 1'b0, o_gpu_nrst);
		reset = 1'b0;
		@(negedge clk_sys);
		check_bit("waitrequest after reset", 1'b0, o_host_waitrequest);
		check_bit("nrst after reset", 1'b1, o_gpu_nrst);
		finish_test();
	endtask

	// two full lines from the first edge after reset
	task automatic test_raster();
		logic [9:0] h;
		logic [8:0] v;
		start_test("video raster");
		for (int n = 0; n < 2 * 768 + 32; n++) begin
			h = cyc % 768;
			v = (cyc / 768) % 512;   // line 1 starts at cycle 768
			check_bit("de", (h < 640) && (v < 480), o_de);
			check_bit("hsync", (h >= 720) && (h <= 735), o_hsync);
			check_bit("vsync", (v >= 500) && (v <= 506), o_vsync);
			check_word("red", h[7:0] ^ v[8:1], o_red);
			check_word("green", h[8:1] ^ v[7:0], o_green);
			check_word("blue", h[9:2] ^ v[8:1], o_blue);
			@(negedge clk_sys);
		end
		finish_test();
	endtask

	task automatic test_gp_writes();
		gpu_host_pkg::word_t data;
		logic [3:0]          ofs [3];
		start_test("gp0/gp1/dma writes");
		ofs = '{`GH_OFS_GP0, `GH_OFS_GP1, `GH_OFS_DMA};
		for (int k = 0; k < 3; k++) begin
			data = next_bits(32);
			host_access(1'b1, {16'h0, ofs[k]}, data);
			check_bit("sel", k != 2, o_gpu_sel);   // dma port has no sel
			check_bit("write", 1'b1, o_gpu_write);
			check_bit("a2", k == 1, o_gpu_a2);
			check_bit("dma_ack", k == 2, o_gpu_dma_ack);
			check_bit("waitrequest busy", 1'b1, o_host_waitrequest);
			check_word("data_in", data, o_gpu_data_in);
			@(negedge clk_sys);
			check_bit("strobes cleared", 1'b0, o_gpu_sel | o_gpu_write | o_gpu_dma_ack);
			check_bit("waitrequest released", 1'b0, o_host_waitrequest);
		end
		finish_test();
	endtask

	task automatic test_gp_reads();
		gpu_host_pkg::word_t        d;
		logic [`GH_HOST_ADDR_W-1:0] addr;
		start_test("gp0/gp1 reads");
		for (int k = 0; k < 6; k++) begin
			addr = (k % 2 == 1) ? {16'h0, `GH_OFS_GP1} : {16'h0, `GH_OFS_GP0};
			host_access(1'b0, addr, '0);
			check_bit("sel", 1'b1, o_gpu_sel);
			check_bit("read", 1'b1, o_gpu_read);
			check_bit("a2", k % 2 == 1, o_gpu_a2);
			check_bit("waitrequest busy", 1'b1, o_host_waitrequest);
			wait_readvalid(d);
			check_word("readdata", resp_word, d);
			check_word("valid to readdatavalid", valid_cyc + 1, cyc);   // next edge
			check_bit("waitrequest with readdatavalid", 1'b0, o_host_waitrequest);
			@(negedge clk_sys);
			check_bit("readdatavalid one cycle", 1'b0, o_host_readdatavalid);
		end
		finish_test();
	endtask

	task automatic test_flags();
		gpu_host_pkg::word_t d;
		gpu_host_pkg::word_t dbg;
		gpu_host_pkg::word_t port;
		start_test("flags and unmapped");
		dbg             = next_bits(32);
		i_gpu_debug_cnt = dbg;
		i_gpu_dma_req   = 1'b1;
		i_gpu_irq       = 1'b0;
		i_gpu_can_write = 1'b1;
		host_access(1'b0, {16'h0, `GH_OFS_FLAGS}, '0);
		check_bit("waitrequest on local read", 1'b0, o_host_waitrequest);
		wait_readvalid(d);
		check_word("flags word", {1'b0, 1'b1, 1'b0, 1'b1, dbg[27:0]}, d);
		host_access(1'b1, {16'h0, `GH_OFS_FLAGS}, 32'h0000_0000);   // run bit off
		check_bit("nrst after run clear", 1'b0, o_gpu_nrst);
		check_bit("no strobe on flags write", 1'b0, o_gpu_sel | o_gpu_write | o_gpu_dma_ack);
		check_bit("flags write busy", 1'b1, o_host_waitrequest);
		host_access(1'b1, {16'h0, `GH_OFS_FLAGS}, 32'h4000_0000);
		check_bit("nrst after run set", 1'b1, o_gpu_nrst);
		host_access(1'b1, {16'h0, `GH_OFS_FLAGS}, 32'hC000_0000);   // dma_ack + run
		check_bit("dma_ack from bit 31", 1'b1, o_gpu_dma_ack);
		@(negedge clk_sys);
		check_bit("dma_ack one cycle", 1'b0, o_gpu_dma_ack);
		check_bit("nrst held", 1'b1, o_gpu_nrst);
		port           = next_bits(32);
		i_gpu_data_out = port;
		host_access(1'b0, {16'h0, `GH_OFS_DMA}, '0);
		wait_readvalid(d);
		check_word("dma port read", port, d);
		@(negedge clk_sys);   // idle cycle between local reads
		check_bit("readdatavalid one cycle", 1'b0, o_host_readdatavalid);
		host_access(1'b0, 20'h00002, '0);   // hole inside the window
		wait_readvalid(d);
		check_word("unmapped read", 32'h0, d);
		@(negedge clk_sys);
		check_bit("readdatavalid one cycle", 1'b0, o_host_readdatavalid);
		host_access(1'b0, 20'h00010, '0);   // above the window
		wait_readvalid(d);
		check_word("read above window", 32'h0, d);
		host_access(1'b1, 20'h00003, 32'hFFFF_FFFF);
		check_bit("unmapped write no wait", 1'b0, o_host_waitrequest);
		check_bit("unmapped write no strobe", 1'b0, o_gpu_sel | o_gpu_write | o_gpu_dma_ack);
		finish_test();
	endtask

	task automatic test_ddr();
		start_test("ddr window");
		for (int k = 0; k < 8; k++) begin
			i_mem_addr  = next_bits(17);
			i_mem_burst = next_bits(3);
			i_mem_we    = next_bits(1);
			i_mem_rd    = next_bits(1);
			i_mem_data  = {next_bits(32), next_bits(32)};
			i_mem_be    = next_bits(8);
			@(posedge clk_sys);   // combinational, settled by now
			check_word("ddr addr", {`GH_DDR_BASE, i_mem_addr}, o_ddr_addr);
			check_word("burst count", {5'd0, i_mem_burst}, o_ddr_burstcnt);
			check_bit("we", i_mem_we, o_ddr_we);
			check_bit("rd", i_mem_rd, o_ddr_rd);
			check_word("data high", i_mem_data[63:32], o_ddr_din[63:32]);
			check_word("data low", i_mem_data[31:0], o_ddr_din[31:0]);
			check_word("byte enables", i_mem_be, o_ddr_be);
			@(negedge clk_sys);
		end
		finish_test();
	endtask

	task automatic test_aspect();
		gpu_host_pkg::aspect_e sels [4];
		logic [7:0]            ex [4];
		logic [7:0]            ey [4];
		start_test("aspect");
		sels = '{gpu_host_pkg::asp_4_3, gpu_host_pkg::asp_8_7, gpu_host_pkg::asp_16_9,
			gpu_host_pkg::asp_2_1};
		ex = '{8'd4, 8'd8, 8'd16, 8'd2};
		ey = '{8'd3, 8'd7, 8'd9, 8'd1};
		for (int k = 0; k < 4; k++) begin
			i_aspect = sels[k];
			@(posedge clk_sys);
			check_aspect(sels[k], ex[k], ey[k]);
			@(negedge clk_sys);
		end
		finish_test();
	endtask

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		int sva_errors;
		errors           = 0;
		tests_run        = 0;
		tests_failed     = 0;
		reset            = 1'b1;
		i_host_address   = '0;
		i_host_write     = 1'b0;
		i_host_read      = 1'b0;
		i_host_writedata = '0;
		i_gpu_data_out   = '0;
		i_gpu_data_valid = 1'b0;
		i_gpu_irq        = 1'b0;
		i_gpu_dma_req    = 1'b0;
		i_gpu_can_write  = 1'b0;
		i_gpu_debug_cnt  = '0;
		i_aspect         = gpu_host_pkg::asp_4_3;
		i_mem_addr       = '0;
		i_mem_burst      = '0;
		i_mem_we         = 1'b0;
		i_mem_rd         = 1'b0;
		i_mem_data       = '0;
		i_mem_be         = '0;
		test_reset();
		test_raster();   // raster expectations start at the first edge after reset
		test_gp_writes();
		test_gp_reads();
		test_flags();
		test_ddr();
		test_aspect();
		sva_errors = gpu_host_top_i.host_reg_bridge_i.gpu_host_sva_i.fail_cnt;
		$display("tests run %0d, tests failed %0d, check errors %0d, assertion errors %0d",
			tests_run, tests_failed, errors, sva_errors);
		if (errors == 0 && sva_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
